// File: hdl/charDecoder.sv
`timescale 1ns/1ps

module charDecoder (
   input  cipherPkg::byte_t      rxData,
   output cipherPkg::charClass_t charInfo
);

   logic isDigit;
   logic isUpperHex;
   logic isLowerHex;

   assign isDigit = (rxData >= cipherPkg::charZero) && (rxData <= cipherPkg::charNine);
   assign isUpperHex = (rxData >= cipherPkg::charUpperA) && (rxData <= cipherPkg::charUpperF);
   assign isLowerHex = (rxData >= cipherPkg::charLowerA) && (rxData <= cipherPkg::charLowerF);

   always_comb begin
      case (rxData)
         cipherPkg::charEncrypt: begin
            charInfo.cmd = cipherPkg::cmdEncrypt;
         end
         cipherPkg::charDecrypt: begin
            charInfo.cmd = cipherPkg::cmdDecrypt;
         end
         cipherPkg::charLoadKey: begin
            charInfo.cmd = cipherPkg::cmdLoadKey;
         end
         cipherPkg::charCr: begin
            charInfo.cmd = cipherPkg::cmdEnd;
         end
         default: begin
            charInfo.cmd = cipherPkg::cmdNone;
         end
      endcase

      // 'D' and 'E' are also hex digits, the controller picks the meaning
      charInfo.isHex = isDigit || isUpperHex || isLowerHex;
      charInfo.isPrintable = (rxData >= cipherPkg::printLow) &&
                             (rxData <= cipherPkg::printHigh);
      charInfo.hexValue = cipherPkg::asciiToNibble(rxData);   // don't care if not hex
      charInfo.rawByte = rxData;
   end

endmodule

// File: hdl/cipherControl.sv
`timescale 1ns/1ps

module cipherControl (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  rxValid,
   input  cipherPkg::charClass_t charInfo,
   output logic                  txValid,
   output logic                  lineDone,
   cipherCtrlIf.ctrl             ctrl
);

   cipherPkg::state_t state;
   cipherPkg::state_t nextState;
   cipherPkg::keyIndex_t keyCount;    // next key digit to write
   logic keyFull;                     // all eight digits written
   logic lineEnd;
   logic startKey;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= cipherPkg::stIdle;
      end else begin
         state <= nextState;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         keyCount <= cipherPkg::keyIndex_t'(cipherPkg::keyDigits - 1);
         keyFull <= 1'b0;
      end else if (startKey) begin
         keyCount <= cipherPkg::keyIndex_t'(cipherPkg::keyDigits - 1);
         keyFull <= 1'b0;
      end else if (ctrl.keyLoad) begin
         if (keyCount == '0) begin
            keyFull <= 1'b1;
         end else begin
            keyCount <= keyCount - 1'b1;
         end
      end
   end

   assign lineEnd = rxValid && (charInfo.cmd == cipherPkg::cmdEnd);
   assign startKey = (state == cipherPkg::stIdle) && rxValid &&
                     (charInfo.cmd == cipherPkg::cmdLoadKey);

   always_comb begin
      nextState = state;
      lineDone = 1'b0;
      ctrl.encLoad = 1'b0;
      ctrl.decHiLoad = 1'b0;
      ctrl.decLoLoad = 1'b0;
      ctrl.keyLoad = 1'b0;
      ctrl.lfsrLoad = 1'b0;
      case (state)
         cipherPkg::stIdle: begin
            if (rxValid) begin
               case (charInfo.cmd)
                  cipherPkg::cmdEncrypt: nextState = cipherPkg::stEncrypt;
                  cipherPkg::cmdDecrypt: nextState = cipherPkg::stDecHi;
                  cipherPkg::cmdLoadKey: nextState = cipherPkg::stLoadKey;
                  default: nextState = cipherPkg::stIdle;   // stray bytes do nothing
               endcase
            end
         end
         cipherPkg::stEncrypt: begin
            if (lineEnd) begin
               lineDone = 1'b1;
               nextState = cipherPkg::stIdle;
            end else if (rxValid && charInfo.isPrintable) begin
               ctrl.encLoad = 1'b1;
               nextState = cipherPkg::stEncHex;
            end
         end
         cipherPkg::stEncHex: nextState = cipherPkg::stEncHi;
         cipherPkg::stEncHi: nextState = cipherPkg::stEncLo;
         cipherPkg::stEncLo: nextState = cipherPkg::stEncrypt;
         cipherPkg::stDecHi: begin
            if (lineEnd) begin
               lineDone = 1'b1;
               nextState = cipherPkg::stIdle;
            end else if (rxValid && charInfo.isHex) begin
               ctrl.decHiLoad = 1'b1;
               nextState = cipherPkg::stDecLo;
            end
         end
         cipherPkg::stDecLo: begin
            if (lineEnd) begin
               lineDone = 1'b1;   // half a pair is dropped
               nextState = cipherPkg::stIdle;
            end else if (rxValid && charInfo.isHex) begin
               ctrl.decLoLoad = 1'b1;
               nextState = cipherPkg::stDecOut;
            end
         end
         cipherPkg::stDecOut: nextState = cipherPkg::stDecHi;
         cipherPkg::stLoadKey: begin
            if (lineEnd) begin
               lineDone = 1'b1;
               ctrl.lfsrLoad = 1'b1;
               nextState = cipherPkg::stIdle;
            end else if (rxValid && charInfo.isHex && !keyFull) begin
               ctrl.keyLoad = 1'b1;
            end
         end
         default: nextState = cipherPkg::stIdle;
      endcase
   end

   assign ctrl.keyIndex = keyCount;
   assign ctrl.hexSelHi = (state == cipherPkg::stEncHi);
   assign ctrl.txSelCipher = (state == cipherPkg::stEncHi) || (state == cipherPkg::stEncLo);
   assign txValid = (state == cipherPkg::stEncHi) || (state == cipherPkg::stEncLo) ||
                    (state == cipherPkg::stDecOut);

endmodule

// File: hdl/cipherCtrlIf.sv
`timescale 1ns/1ps

interface cipherCtrlIf;

   logic encLoad;                     // take a plaintext byte, step lfsr
   logic decHiLoad;                   // first ciphertext digit
   logic decLoLoad;                   // second ciphertext digit, step lfsr
   logic keyLoad;
   cipherPkg::keyIndex_t keyIndex;    // 7 is the most significant digit
   logic lfsrLoad;
   logic hexSelHi;                    // high hex digit on txData
   logic txSelCipher;                 // hex output instead of plaintext

   modport ctrl (
      output encLoad, decHiLoad, decLoLoad, keyLoad, keyIndex, lfsrLoad,
      output hexSelHi, txSelCipher
   );

   modport keys (
      input encLoad, decLoLoad, keyLoad, keyIndex, lfsrLoad
   );

   modport fmt (
      input encLoad, decHiLoad, decLoLoad, hexSelHi, txSelCipher
   );

endinterface

// File: hdl/cipherPkg.sv
package cipherPkg;

   localparam int byteWidth = 8;
   localparam int nibbleWidth = 4;
   localparam int keyWidth = 32;
   localparam int keyDigits = 8;

   // x^32 + x^22 + x^2 + x + 1, right-shifting Galois form
   localparam logic [keyWidth-1:0] lfsrTaps = 32'h8020_0003;

   localparam logic [byteWidth-1:0] charCr = 8'h0D;
   localparam logic [byteWidth-1:0] charEncrypt = 8'h45;    // 'E'
   localparam logic [byteWidth-1:0] charDecrypt = 8'h44;    // 'D'
   localparam logic [byteWidth-1:0] charLoadKey = 8'h4C;    // 'L'
   localparam logic [byteWidth-1:0] printLow = 8'h20;
   localparam logic [byteWidth-1:0] printHigh = 8'h7E;
   localparam logic [byteWidth-1:0] charSubstitute = 8'h2E; // '.'

   localparam logic [byteWidth-1:0] charZero = 8'h30;
   localparam logic [byteWidth-1:0] charNine = 8'h39;
   localparam logic [byteWidth-1:0] charUpperA = 8'h41;
   localparam logic [byteWidth-1:0] charUpperF = 8'h46;
   localparam logic [byteWidth-1:0] charLowerA = 8'h61;
   localparam logic [byteWidth-1:0] charLowerF = 8'h66;

   typedef logic [byteWidth-1:0] byte_t;
   typedef logic [nibbleWidth-1:0] nibble_t;
   typedef logic [keyWidth-1:0] key_t;
   typedef logic [$clog2(keyDigits)-1:0] keyIndex_t;

   typedef enum logic [2:0] {
      cmdNone,
      cmdEncrypt,
      cmdDecrypt,
      cmdLoadKey,
      cmdEnd
   } cmd_t;

   typedef enum logic [3:0] {
      stIdle,
      stEncrypt,
      stEncHex,   // xor result is being turned into hex digits
      stEncHi,
      stEncLo,
      stDecHi,
      stDecLo,
      stDecOut,
      stLoadKey
   } state_t;

   typedef struct packed {
      cmd_t cmd;
      logic isHex;
      logic isPrintable;
      nibble_t hexValue;
      byte_t rawByte;
   } charClass_t;

   // valid for 0-9, A-F and a-f only; letters carry bit 6
   function automatic nibble_t asciiToNibble(byte_t c);
      nibble_t v;
      v = c[nibbleWidth-1:0] + (c[6] ? nibble_t'(9) : nibble_t'(0));
      return v;
   endfunction

endpackage

// File: hdl/keystream.sv
`timescale 1ns/1ps

module keystream (
   input  logic             clk,
   input  logic             rst,
   input  cipherPkg::byte_t rxData,
   cipherCtrlIf.keys        keys,
   output cipherPkg::byte_t psrByte
);

   cipherPkg::key_t keyReg;    // eight nibbles, digit 7 on top
   cipherPkg::key_t lfsr;
   cipherPkg::key_t lfsrNext;
   logic step;

   always_ff @(posedge clk) begin
      if (rst) begin
         keyReg <= '0;
      end else if (keys.keyLoad) begin
         keyReg[keys.keyIndex * cipherPkg::nibbleWidth +: cipherPkg::nibbleWidth] <=
            cipherPkg::asciiToNibble(rxData);
      end
   end

   // one step per processed character
   assign step = keys.encLoad || keys.decLoLoad;

   always_comb begin
      lfsrNext = lfsr >> 1;
      if (lfsr[0]) begin
         lfsrNext = lfsrNext ^ cipherPkg::lfsrTaps;   // feedback on the bit shifted out
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         lfsr <= '0;
      end else if (keys.lfsrLoad) begin
         lfsr <= keyReg;
      end else if (step) begin
         lfsr <= lfsrNext;
      end
   end

   assign psrByte = lfsr[cipherPkg::byteWidth-1:0];   // valid the cycle after the step

endmodule

// File: hdl/streamCipher.sv
`timescale 1ns/1ps

module streamCipher (
   input  logic             clk,
   input  logic             rst,
   input  logic             rxValid,     // one-cycle pulse per received byte
   input  cipherPkg::byte_t rxData,
   output logic             txValid,
   output cipherPkg::byte_t txData,
   output logic             lineDone
);

   cipherPkg::charClass_t charInfo;
   cipherPkg::byte_t psrByte;

   cipherCtrlIf ctrlBus ();

   charDecoder u_decoder (
      .rxData   (rxData),
      .charInfo (charInfo)
   );

   cipherControl u_control (
      .clk      (clk),
      .rst      (rst),
      .rxValid  (rxValid),
      .charInfo (charInfo),
      .txValid  (txValid),
      .lineDone (lineDone),
      .ctrl     (ctrlBus.ctrl)
   );

   keystream u_keystream (
      .clk     (clk),
      .rst     (rst),
      .rxData  (rxData),
      .keys    (ctrlBus.keys),
      .psrByte (psrByte)
   );

   txFormatter u_formatter (
      .clk     (clk),
      .rst     (rst),
      .rxData  (rxData),
      .psrByte (psrByte),
      .fmt     (ctrlBus.fmt),
      .txData  (txData)
   );

endmodule

// File: hdl/txFormatter.sv
`timescale 1ns/1ps

module txFormatter (
   input  logic             clk,
   input  logic             rst,
   input  cipherPkg::byte_t rxData,
   input  cipherPkg::byte_t psrByte,
   cipherCtrlIf.fmt         fmt,
   output cipherPkg::byte_t txData
);

   cipherPkg::byte_t encByte;      // plaintext waiting for the fresh keystream byte
   cipherPkg::byte_t encXor;
   cipherPkg::byte_t hexHi;
   cipherPkg::byte_t hexLo;
   cipherPkg::nibble_t decHi;
   cipherPkg::nibble_t decLo;
   cipherPkg::byte_t plainByte;
   cipherPkg::byte_t plainChar;
   logic hexLoad;

   function automatic cipherPkg::byte_t nibbleToAscii(cipherPkg::nibble_t n);
      cipherPkg::byte_t c;
      if (n < 4'd10) begin
         c = cipherPkg::charZero + cipherPkg::byte_t'(n);
      end else begin
         c = cipherPkg::charUpperA + cipherPkg::byte_t'(n) - 8'd10;
      end
      return c;
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         hexLoad <= 1'b0;
      end else begin
         hexLoad <= fmt.encLoad;   // lfsr has stepped by then
      end
   end

   assign encXor = encByte ^ psrByte;

   always_ff @(posedge clk) begin
      if (fmt.encLoad) begin
         encByte <= rxData;
      end
      if (hexLoad) begin
         hexHi <= nibbleToAscii(encXor[7:4]);
         hexLo <= nibbleToAscii(encXor[3:0]);
      end
      if (fmt.decHiLoad) begin
         decHi <= cipherPkg::asciiToNibble(rxData);
      end
      if (fmt.decLoLoad) begin
         decLo <= cipherPkg::asciiToNibble(rxData);
      end
   end

   assign plainByte = {decHi, decLo} ^ psrByte;
   assign plainChar = ((plainByte >= cipherPkg::printLow) && (plainByte <= cipherPkg::printHigh)) ?
                      plainByte : cipherPkg::charSubstitute;

   assign txData = fmt.txSelCipher ? (fmt.hexSelHi ? hexHi : hexLo) : plainChar;

endmodule

// File: run.sh
#!/bin/sh
# Compile and run the streamCipher testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_streamCipher -f streamCipher.f

# assertion failures are counted by the testbench, so keep running after one
simOutput=$(./obj_dir/Vtb_streamCipher +verilator+error+limit+1000)
echo "$simOutput"

echo "$simOutput" | grep -q "^STATUS: PASS$"

// File: streamCipher.f
hdl/cipherPkg.sv
hdl/cipherCtrlIf.sv
hdl/charDecoder.sv
hdl/cipherControl.sv
hdl/keystream.sv
hdl/txFormatter.sv
hdl/streamCipher.sv
testbench/streamCipher_sva.sv
testbench/tb_streamCipher.sv

// File: testbench/streamCipher_sva.sv
`timescale 1ns/1ps

module streamCipher_sva (
   input logic clk,
   input logic rst,
   input logic txValid,
   input logic lineDone,
   input logic encLoad,
   input logic decHiLoad,
   input logic decLoLoad,
   input logic keyLoad,
   input logic lfsrLoad
);

   int assertFails = 0;   // picked up by the testbench summary

   assert property (@(posedge clk) disable iff (rst) !(txValid && lineDone))
      else begin
         $error("txValid and lineDone high in the same cycle");
         assertFails++;
      end

   // only one data strobe per cycle
   assert property (@(posedge clk) disable iff (rst) $onehot0({encLoad, decHiLoad, decLoLoad}))
      else begin
         $error("more than one of encLoad, decHiLoad, decLoLoad active");
         assertFails++;
      end

   assert property (@(posedge clk)
                    rst |-> !(encLoad || decHiLoad || decLoLoad || keyLoad || lfsrLoad))
      else begin
         $error("control strobe active during reset");
         assertFails++;
      end

endmodule

bind cipherControl streamCipher_sva u_sva (
   .clk       (clk),
   .rst       (rst),
   .txValid   (txValid),
   .lineDone  (lineDone),
   .encLoad   (ctrl.encLoad),
   .decHiLoad (ctrl.decHiLoad),
   .decLoLoad (ctrl.decLoLoad),
   .keyLoad   (ctrl.keyLoad),
   .lfsrLoad  (ctrl.lfsrLoad)
);

// File: testbench/tb_streamCipher.sv
`timescale 1ns/1ps

module tb_streamCipher;

   localparam int byteGap = 6;      // cycles spent on each sent byte
   localparam int byteCount = 90;   // bytes sent over all tests, rounded up
   localparam int cycleLimit = byteCount * byteGap + 200;

   logic clk = 1'b0;
   logic rst;
   logic rxValid;
   cipherPkg::byte_t rxData;
   logic txValid;
   cipherPkg::byte_t txData;
   logic lineDone;

   int cycle = 0;
   int errorCount = 0;
   int checkCount = 0;
   int lineCount = 0;
   int sentCycle;                   // cycle in which the last byte was valid
   logic [31:0] rngState = 32'd24373;
   cipherPkg::key_t modelLfsr;
   cipherPkg::byte_t txQ[$];
   int txCycleQ[$];

   streamCipher u_dut (
      .clk      (clk),
      .rst      (rst),
      .rxValid  (rxValid),
      .rxData   (rxData),
      .txValid  (txValid),
      .txData   (txData),
      .lineDone (lineDone)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle = cycle + 1;
      if (cycle > cycleLimit) begin
         $display("timeout: tests did not finish within %0d cycles", cycleLimit);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // outputs are settled mid-cycle
   always @(negedge clk) begin
      if (!rst && txValid) begin
         txQ.push_back(txData);
         txCycleQ.push_back(cycle);
      end
      if (!rst && lineDone) begin
         lineCount++;
      end
   end

   function automatic logic [31:0] nextRandom();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   function automatic cipherPkg::key_t lfsrStep(cipherPkg::key_t s);
      cipherPkg::key_t n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ cipherPkg::lfsrTaps;
      end
      return n;
   endfunction

   function automatic int hexValue(cipherPkg::byte_t c);
      if (c >= "0" && c <= "9") return int'(c - "0");
      if (c >= "A" && c <= "F") return int'(c - "A") + 10;
      if (c >= "a" && c <= "f") return int'(c - "a") + 10;
      return -1;   // not a hex digit
   endfunction

   function automatic cipherPkg::byte_t hexChar(cipherPkg::nibble_t n);
      return (n < 10) ? cipherPkg::byte_t'("0" + n) : cipherPkg::byte_t'("A" + n - 10);
   endfunction

   function automatic bit isPrintable(cipherPkg::byte_t c);
      return (c >= cipherPkg::printLow) && (c <= cipherPkg::printHigh);
   endfunction

   task automatic compareByte(input string name, input cipherPkg::byte_t expected,
                              input cipherPkg::byte_t actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("FAIL %0t %s: expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   task automatic comparePulse(input string name, input logic expected, input logic actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("FAIL %0t %s: expected %b, got %b", $time, name, expected, actual);
      end
   endtask

   task automatic compareCount(input string name, input int expected, input int actual);
      checkCount++;
      if (actual != expected) begin
         errorCount++;
         $display("FAIL %0t %s: expected %0d, got %0d", $time, name, expected, actual);
      end
   endtask

   task automatic compareText(input string name, input string expected, input string actual);
      compareCount({name, " length"}, expected.len(), actual.len());
      for (int i = 0; i < expected.len() && i < actual.len(); i++) begin
         compareByte(name, expected[i], actual[i]);
      end
   endtask

   // called 1 ns after a rising edge, returns at the same point byteGap cycles later
   task automatic sendByte(input cipherPkg::byte_t b, input logic expLine);
      rxData = b;
      rxValid = 1'b1;
      sentCycle = cycle;
      @(negedge clk);
      comparePulse("lineDone", expLine, lineDone);
      @(posedge clk);
      #1;
      rxValid = 1'b0;
      repeat (byteGap - 1) @(posedge clk);
      #1;
   endtask

   task automatic loadKeyText(input string digits);
      sendByte(cipherPkg::charLoadKey, 1'b0);
      modelLfsr = '0;
      for (int i = 0; i < digits.len(); i++) begin
         sendByte(digits[i], 1'b0);
         modelLfsr = (modelLfsr << 4) | cipherPkg::key_t'(hexValue(digits[i]));
      end
      sendByte(cipherPkg::charCr, 1'b1);
   endtask

   task automatic encryptText(input string text, output string hexOut);
      cipherPkg::byte_t expected[$];
      cipherPkg::byte_t x;
      int sent[$];
      txQ.delete();
      txCycleQ.delete();
      sendByte(cipherPkg::charEncrypt, 1'b0);
      for (int i = 0; i < text.len(); i++) begin
         sendByte(text[i], 1'b0);
         if (isPrintable(text[i])) begin
            modelLfsr = lfsrStep(modelLfsr);
            x = text[i] ^ modelLfsr[7:0];
            expected.push_back(hexChar(x[7:4]));
            expected.push_back(hexChar(x[3:0]));
            sent.push_back(sentCycle);
         end
      end
      sendByte(cipherPkg::charCr, 1'b1);
      compareCount("encrypt output count", expected.size(), txQ.size());
      hexOut = "";
      for (int i = 0; i < expected.size() && i < txQ.size(); i++) begin
         compareByte("txData", expected[i], txQ[i]);
         compareCount("txValid cycle", sent[i / 2] + 2 + (i % 2), txCycleQ[i]);
         hexOut = $sformatf("%s%c", hexOut, txQ[i]);
      end
   endtask

   task automatic decryptText(input string hexText, output string plain);
      cipherPkg::byte_t expected[$];
      cipherPkg::byte_t p;
      int hi;
      int v;
      hi = -1;
      txQ.delete();
      txCycleQ.delete();
      sendByte(cipherPkg::charDecrypt, 1'b0);
      for (int i = 0; i < hexText.len(); i++) begin
         v = hexValue(hexText[i]);
         sendByte(hexText[i], 1'b0);
         if (v >= 0 && hi < 0) begin
            hi = v;
         end else if (v >= 0) begin
            modelLfsr = lfsrStep(modelLfsr);
            p = cipherPkg::byte_t'(hi * 16 + v) ^ modelLfsr[7:0];
            expected.push_back(isPrintable(p) ? p : cipherPkg::charSubstitute);
            compareCount("plaintext cycle", sentCycle + 1,
                         (txCycleQ.size() > 0) ? txCycleQ[$] : -1);
            hi = -1;
         end
      end
      sendByte(cipherPkg::charCr, 1'b1);
      compareCount("decrypt output count", expected.size(), txQ.size());
      plain = "";
      for (int i = 0; i < expected.size() && i < txQ.size(); i++) begin
         compareByte("txData", expected[i], txQ[i]);
         plain = $sformatf("%s%c", plain, txQ[i]);
      end
   endtask

   task automatic testIdle();
      txQ.delete();
      lineCount = 0;
      repeat (20) @(posedge clk);
      #1;
      compareCount("txValid pulses while idle", 0, txQ.size());
      compareCount("lineDone pulses while idle", 0, lineCount);
   endtask

   task automatic testRoundTrip();
      string hexOut;
      string plain;
      string keyText;
      string text;
      loadKeyText("1234ABCD");
      encryptText("Hi", hexOut);
      loadKeyText("1234ABCD");
      decryptText(hexOut, plain);
      compareText("decrypted text", "Hi", plain);
      keyText = $sformatf("%08x", nextRandom());   // lower case digits
      text = "";
      for (int i = 0; i < 6; i++) begin
         text = $sformatf("%s%c", text, cipherPkg::printLow + 8'(nextRandom() % 95));
      end
      loadKeyText(keyText);
      encryptText(text, hexOut);
      loadKeyText(keyText);
      decryptText(hexOut, plain);
      compareText("random round trip", text, plain);
   endtask

   task automatic testSubstitute();
      cipherPkg::key_t ahead;
      cipherPkg::byte_t cipherByte;
      string plain;
      ahead = lfsrStep(modelLfsr);
      cipherByte = ahead[7:0] ^ 8'h01;   // plaintext becomes a control code
      decryptText($sformatf("%czG%c", hexChar(cipherByte[7:4]), hexChar(cipherByte[3:0])),
                  plain);
      compareByte("substitute char", cipherPkg::charSubstitute,
                  (plain.len() > 0) ? plain[0] : 8'h00);
   endtask

   task automatic testEncryptFilter();
      string hexOut;
      encryptText("A\007b", hexOut);
      txQ.delete();
      sendByte("Q", 1'b0);
      sendByte(cipherPkg::charCr, 1'b0);   // no line end from idle
      compareCount("output from idle bytes", 0, txQ.size());
   endtask

   initial begin
      rst = 1'b1;
      rxValid = 1'b0;
      rxData = '0;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      testIdle();
      testRoundTrip();
      testSubstitute();
      testEncryptFilter();
      errorCount = errorCount + u_dut.u_control.u_sva.assertFails;
      $display("checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule
